// File: rtl/sandbox_defines.svh
// ------------------------------
// work memory geometry and
// control byte bit positions
// ------------------------------
`ifndef SANDBOX_DEFINES_SVH
`define SANDBOX_DEFINES_SVH

// work memory
`define SANDBOX_MEM_DEPTH   16   // words in the work memory
`define SANDBOX_ADDR_WIDTH  4    // bits per word address

// control byte layout
`define CMD_RUN_BIT         0    // start checksum engine
`define CMD_WRITE_BIT       1    // store data word, wins over run
`define CMD_ADDR_LSB        4    // write address in bits 7..4

`endif

// File: rtl/sandboxPkg.sv
// ------------------------------
// host command and reply structs,
// memory request and response structs
// ------------------------------
`include "sandbox_defines.svh"

package sandboxPkg;

  // host link side
  typedef struct packed {
    logic [7:0]  control;     // command flags and write address
    logic [31:0] data;        // payload word
  } hostCommand_t;

  typedef struct packed {
    logic [7:0]  status;      // bit 0 running, bit 1 last success
    logic [31:0] outputWord;  // last checksum
  } hostReply_t;

  // ------------------------------
  // work memory port, one per peer
  // ------------------------------
  typedef struct packed {
    logic                           valid;        // request pending
    logic                           writeEnable;  // store when set, else read
    logic [`SANDBOX_ADDR_WIDTH-1:0] address;
    logic [31:0]                    writeData;
  } memRequest_t;

  typedef struct packed {
    logic        grant;       // request taken this cycle
    logic        readValid;   // read word one cycle after grant
    logic [31:0] readData;
  } memResponse_t;

endpackage

// File: rtl/workMemory.sv
// ------------------------------
// work memory, single port,
// registered read
// ------------------------------
`timescale 1ns/1ps
`include "sandbox_defines.svh"

module workMemory (
  input  logic                           masterClock,
  input  logic                           memEnable,
  input  logic                           memWrite,      // store when set
  input  logic [`SANDBOX_ADDR_WIDTH-1:0] memAddress,
  input  logic [31:0]                    memWriteData,
  output logic [31:0]                    memReadData    // valid cycle after enable
);

  logic [31:0] storage [`SANDBOX_MEM_DEPTH];   // contents survive reset

  always_ff @(posedge masterClock)
  begin
    if (memEnable)
    begin
      if (memWrite)
        storage[memAddress] <= memWriteData;
      else
        memReadData <= storage[memAddress];
    end
  end

endmodule

// File: rtl/memoryArbiter.sv
// ------------------------------
// fixed-priority work memory arbiter
// ------------------------------
`timescale 1ns/1ps
`include "sandbox_defines.svh"

module memoryArbiter import sandboxPkg::*; (
  input  logic                           masterClock,
  input  logic                           reset,           // sync, active low
  input  memRequest_t                    hostRequest,     // sandbox process, high priority
  input  memRequest_t                    engineRequest,
  output memResponse_t                   hostResponse,
  output memResponse_t                   engineResponse,
  output logic                           memEnable,
  output logic                           memWrite,
  output logic [`SANDBOX_ADDR_WIDTH-1:0] memAddress,
  output logic [31:0]                    memWriteData,
  input  logic [31:0]                    memReadData
);

  logic hostGrant, engineGrant;
  logic hostReadPending, engineReadPending;     // owner of the returning word

  assign hostGrant   = hostRequest.valid;
  assign engineGrant = engineRequest.valid && !hostRequest.valid;

  // ------------------------------
  // memory port mux
  // ------------------------------
  assign memEnable    = hostGrant || engineGrant;
  assign memWrite     = hostGrant ? hostRequest.writeEnable : engineRequest.writeEnable;
  assign memAddress   = hostGrant ? hostRequest.address     : engineRequest.address;
  assign memWriteData = hostGrant ? hostRequest.writeData   : engineRequest.writeData;

  assign hostResponse   = '{grant: hostGrant, readValid: hostReadPending,
                            readData: memReadData};
  assign engineResponse = '{grant: engineGrant, readValid: engineReadPending,
                            readData: memReadData};

  always_ff @(posedge masterClock)
  begin
    if (!reset)
    begin
      hostReadPending   <= 1'b0;
      engineReadPending <= 1'b0;
    end
    else
    begin
      hostReadPending   <= hostGrant && !hostRequest.writeEnable;
      engineReadPending <= engineGrant && !engineRequest.writeEnable;
    end
  end

endmodule

// File: rtl/checksumEngine.sv
// ------------------------------
// checksum engine, scans the work
// memory and judges the sum
// ------------------------------
`timescale 1ns/1ps
`include "sandbox_defines.svh"

module checksumEngine import sandboxPkg::*; (
  input  logic         masterClock,
  input  logic         reset,         // sync, active low
  input  logic         startRun,      // ignored while busy
  input  logic [31:0]  expectedSum,
  output memRequest_t  memRequest,    // read-only port
  input  memResponse_t memResponse,
  output logic         running,
  output logic         lastSuccess,
  output logic [31:0]  lastSum
);

  localparam logic [`SANDBOX_ADDR_WIDTH-1:0] LastAddress =
    `SANDBOX_ADDR_WIDTH'(`SANDBOX_MEM_DEPTH - 1);

  logic [`SANDBOX_ADDR_WIDTH-1:0] readAddress;    // next read to issue
  logic [`SANDBOX_ADDR_WIDTH-1:0] receiveCount;   // words summed so far
  logic                           issueDone;      // all reads granted
  logic [31:0]                    expectedReg;
  logic [31:0]                    accumulator;
  logic [31:0]                    nextSum;

  assign nextSum    = accumulator + memResponse.readData;   // 32-bit wrap
  assign memRequest = '{valid: running && !issueDone, writeEnable: 1'b0,
                        address: readAddress, writeData: '0};

  // ------------------------------
  // scan control
  // ------------------------------
  always_ff @(posedge masterClock)
  begin
    if (!reset)
    begin
      running      <= 1'b0;
      issueDone    <= 1'b0;
      readAddress  <= '0;
      receiveCount <= '0;
      lastSuccess  <= 1'b0;
      lastSum      <= '0;
    end
    else if (!running)
    begin
      if (startRun)
      begin
        running      <= 1'b1;                     // edge after startRun
        issueDone    <= 1'b0;
        readAddress  <= '0;
        receiveCount <= '0;
      end
    end
    else
    begin
      if (memRequest.valid && memResponse.grant)
      begin
        readAddress <= readAddress + 1'b1;        // advance on grant
        if (readAddress == LastAddress)
          issueDone <= 1'b1;
      end
      if (memResponse.readValid)
      begin
        receiveCount <= receiveCount + 1'b1;
        if (receiveCount == LastAddress)          // sixteenth word
        begin
          running     <= 1'b0;
          lastSum     <= nextSum;
          lastSuccess <= (nextSum == expectedReg);
        end
      end
    end
  end

  // sum datapath
  always_ff @(posedge masterClock)
  begin
    if (!running && startRun)
    begin
      expectedReg <= expectedSum;
      accumulator <= '0;
    end
    else if (memResponse.readValid)
      accumulator <= nextSum;
  end

endmodule

// File: rtl/sandboxProcess.sv
// ------------------------------
// host command FSM, reply registers,
// write port and user indicator
// ------------------------------
`timescale 1ns/1ps
`include "sandbox_defines.svh"

module sandboxProcess import sandboxPkg::*; (
  input  logic         masterClock,
  input  logic         reset,         // sync, active low
  input  logic         slowClock,     // indicator timing
  input  logic         dataReceived,
  input  hostCommand_t command,
  output logic         clearDR,
  output logic         transmitData,
  output hostReply_t   reply,
  output logic         rxIndicator,
  output memRequest_t  memRequest,    // write-only port
  input  memResponse_t memResponse,
  output logic         startRun,
  output logic [31:0]  expectedSum,
  input  logic         running,
  input  logic         lastSuccess,
  input  logic [31:0]  lastSum
);

  typedef enum logic [2:0] {ACCEPT, TRANSMIT, WAIT, CLEAR, RELEASE} cmdState_t;
  typedef enum logic [2:0] {IND_IDLE, IND_HIGH1, IND_LOW1, IND_HIGH2, IND_LOW2} indState_t;

  cmdState_t                      state;
  indState_t                      indState;
  logic                           isWrite, isRun;   // decoded at accept
  logic                           writeValid;
  logic [`SANDBOX_ADDR_WIDTH-1:0] writeAddress;
  logic [31:0]                    dataWord;         // payload, no reset
  logic [1:0]                     slowSync;         // two-flop synchronizer
  logic                           indArmed;

  assign expectedSum = dataWord;
  assign memRequest  = '{valid: writeValid, writeEnable: 1'b1,
                         address: writeAddress, writeData: dataWord};

  // ------------------------------
  // command sequence
  // ------------------------------
  always_ff @(posedge masterClock)
  begin
    if (!reset)
    begin
      state        <= ACCEPT;
      isWrite      <= 1'b0;
      isRun        <= 1'b0;
      writeValid   <= 1'b0;
      startRun     <= 1'b0;
      transmitData <= 1'b0;
      clearDR      <= 1'b0;
      reply        <= '0;
    end
    else
    begin
      startRun <= 1'b0;                               // one-cycle pulse
      if (writeValid && memResponse.grant)
        writeValid <= 1'b0;                           // store taken
      case (state)
        ACCEPT:
          if (dataReceived)                           // edge 0
          begin
            isWrite <= command.control[`CMD_WRITE_BIT];
            isRun   <= !command.control[`CMD_WRITE_BIT] && command.control[`CMD_RUN_BIT];
            if (!command.control[`CMD_WRITE_BIT] && !command.control[`CMD_RUN_BIT])
            begin
              reply.status[0] <= running;             // query
              if (!running)
                reply.status[1] <= lastSuccess;       // keep old while busy
              reply.outputWord <= lastSum;
            end
            state <= TRANSMIT;
          end
        TRANSMIT:
        begin
          transmitData <= 1'b1;                       // edge 1
          writeValid   <= isWrite;
          startRun     <= isRun;
          state        <= WAIT;
        end
        WAIT:
          state <= CLEAR;
        CLEAR:
        begin
          clearDR <= 1'b1;                            // edge 3
          state   <= RELEASE;
        end
        RELEASE:
          if (!dataReceived)
          begin
            transmitData <= 1'b0;                     // both drop together
            clearDR      <= 1'b0;
            state        <= ACCEPT;
          end
        default:
          state <= ACCEPT;
      endcase
    end
  end

  // payload of the accepted command
  always_ff @(posedge masterClock)
  begin
    if (state == ACCEPT && dataReceived)
    begin
      writeAddress <= command.control[`CMD_ADDR_LSB +: `SANDBOX_ADDR_WIDTH];
      dataWord     <= command.data;
    end
  end

  // ------------------------------
  // user indicator
  // ------------------------------
  always_ff @(posedge masterClock)
  begin
    if (!reset)
    begin
      slowSync    <= 2'b00;
      indState    <= IND_IDLE;
      indArmed    <= 1'b0;
      rxIndicator <= 1'b0;
    end
    else
    begin
      slowSync <= {slowSync[0], slowClock};
      if (state == ACCEPT && dataReceived)
        indArmed <= 1'b1;                             // accepted command
      case (indState)
        IND_IDLE:
          if (indArmed)
          begin
            indArmed <= 1'b0;
            indState <= IND_HIGH1;
          end
        IND_HIGH1:
          if (slowSync[1])
            indState <= IND_LOW1;
        IND_LOW1:
          if (!slowSync[1])
          begin
            rxIndicator <= 1'b1;                      // pulse starts
            indState    <= IND_HIGH2;
          end
        IND_HIGH2:
          if (slowSync[1])
            indState <= IND_LOW2;
        IND_LOW2:
          if (!slowSync[1])
          begin
            rxIndicator <= 1'b0;
            indState    <= IND_IDLE;
          end
        default:
          indState <= IND_IDLE;
      endcase
    end
  end

endmodule

// File: rtl/sandboxTop.sv
// ------------------------------
// sandbox top, process, engine,
// arbiter and work memory
// ------------------------------
`timescale 1ns/1ps
`include "sandbox_defines.svh"

module sandboxTop import sandboxPkg::*; (
  input  logic         masterClock,
  input  logic         reset,         // sync, active low
  input  logic         slowClock,
  input  logic         dataReceived,
  input  hostCommand_t command,
  output logic         clearDR,
  output logic         transmitData,
  output hostReply_t   reply,
  output logic         rxIndicator
);

  // ------------------------------
  // peer wiring
  // ------------------------------
  memRequest_t                    hostRequest, engineRequest;
  memResponse_t                   hostResponse, engineResponse;
  logic                           startRun, running, lastSuccess;
  logic [31:0]                    expectedSum, lastSum;
  logic                           memEnable, memWrite;
  logic [`SANDBOX_ADDR_WIDTH-1:0] memAddress;
  logic [31:0]                    memWriteData, memReadData;

  sandboxProcess process (
    .masterClock, .reset, .slowClock, .dataReceived, .command,
    .clearDR, .transmitData, .reply, .rxIndicator,
    .memRequest(hostRequest), .memResponse(hostResponse),
    .startRun, .expectedSum, .running, .lastSuccess, .lastSum
  );

  checksumEngine engine (
    .masterClock, .reset, .startRun, .expectedSum,
    .memRequest(engineRequest), .memResponse(engineResponse),
    .running, .lastSuccess, .lastSum
  );

  memoryArbiter arbiter (
    .masterClock, .reset, .hostRequest, .engineRequest, .hostResponse, .engineResponse,
    .memEnable, .memWrite, .memAddress, .memWriteData, .memReadData
  );

  workMemory memory (.masterClock, .memEnable, .memWrite, .memAddress, .memWriteData, .memReadData);

endmodule

// File: testbench/sandbox_assertions.sv
// ------------------------------
// bound checks on the host handshake
// and the engine memory request
// ------------------------------
`timescale 1ns/1ps
`include "sandbox_defines.svh"

module sandboxAssertions (
  input logic                           masterClock,
  input logic                           reset,          // sync, active low
  input logic                           transmitData,
  input logic                           clearDR,
  input logic                           engineValid,
  input logic                           engineGrant,
  input logic [`SANDBOX_ADDR_WIDTH-1:0] engineAddress
);

  // clearDR only during a reply
  clearNeedsTransmit: assert property (@(posedge masterClock) disable iff (!reset)
    $rose(clearDR) |-> transmitData)
    else $error("clearDR rose while transmitData was low");

  // engine keeps its read until the arbiter takes it
  engineHold: assert property (@(posedge masterClock) disable iff (!reset)
    engineValid && !engineGrant |=> engineValid && $stable(engineAddress))
    else $error("engine request dropped or moved before grant");

  handshakeRelease: assert property (@(posedge masterClock) disable iff (!reset)
    $fell(transmitData) |-> $fell(clearDR))
    else $error("transmitData fell without clearDR");

  clearRelease: assert property (@(posedge masterClock) disable iff (!reset)
    $fell(clearDR) |-> $fell(transmitData))
    else $error("clearDR fell without transmitData");

endmodule

bind sandboxTop sandboxAssertions checks (
  .masterClock, .reset, .transmitData, .clearDR,
  .engineValid(engineRequest.valid), .engineGrant(engineResponse.grant),
  .engineAddress(engineRequest.address)
);

// File: testbench/sandboxTb.sv
// ------------------------------
// sandbox testbench, clocks, reset,
// file-driven host commands and checks
// ------------------------------
`timescale 1ns/1ps
`include "sandbox_defines.svh"

module sandboxTb import sandboxPkg::*; ();

  localparam int HandshakeLimit = 20;    // cycles per handshake step
  localparam int PulseLimit     = 100;   // cycles to drain indicator pulses
  localparam int PollLimit      = 10;    // queries before giving up

  logic         masterClock;
  logic         reset;
  logic         slowClock;
  logic         dataReceived;
  hostCommand_t command;
  logic         clearDR;
  logic         transmitData;
  hostReply_t   reply;
  logic         rxIndicator;

  int           issuedCount = 0;         // commands sent
  int           risingCount = 0;         // rxIndicator rising edges
  int           checkCount  = 0;
  int           errorCount  = 0;
  logic         runAborted  = 1'b0;      // a wait timed out
  logic         indPrevious = 1'b0;
  hostReply_t   gotReply;                // reply seen with transmitData

  sandboxTop uut (.masterClock, .reset, .slowClock, .dataReceived, .command,
                  .clearDR, .transmitData, .reply, .rxIndicator);

  // ------------------------------
  // clocks
  // ------------------------------
  initial
  begin
    masterClock = 1'b0;
    forever #4 masterClock = ~masterClock;    // 8 ns
  end

  initial
  begin
    slowClock = 1'b0;
    forever
    begin
      repeat (4) @(negedge masterClock);      // 64 ns, away from rising edges
      slowClock = ~slowClock;
    end
  end

  always @(posedge masterClock)
  begin
    if (rxIndicator && !indPrevious)
      risingCount <= risingCount + 1;
    indPrevious <= rxIndicator;
  end

  task automatic stepClock();
    @(posedge masterClock);
    #1;                                       // drive and sample after the edge
  endtask

  task automatic checkValue(input string name, input logic [31:0] actual,
                            input logic [31:0] expected);
    checkCount++;
    if (actual !== expected)
    begin
      errorCount++;
      $display("FAIL %s: got %h, expected %h", name, actual, expected);
    end
  endtask

  task automatic reportTimeout(input string what);
    $display("timeout while waiting for %s", what);
    runAborted = 1'b1;
  endtask

  // one host transfer, up to the release of transmitData
  task automatic sendCommand(input logic [7:0] control, input logic [31:0] data);
    int cycles;
    if (runAborted)
      return;
    command      = '{control: control, data: data};
    dataReceived = 1'b1;
    cycles       = 0;
    while (!transmitData && cycles < HandshakeLimit)
    begin
      stepClock();
      cycles++;
    end
    if (!transmitData)
      reportTimeout("transmitData to rise");
    gotReply = reply;                         // reply valid with transmitData
    cycles   = 0;
    while (!clearDR && cycles < HandshakeLimit)
    begin
      stepClock();
      cycles++;
    end
    if (!clearDR)
      reportTimeout("clearDR to rise");
    checkValue("transmitData", 32'(transmitData), 32'h1);    // held with clearDR
    dataReceived = 1'b0;
    cycles       = 0;
    while (transmitData && cycles < HandshakeLimit)
    begin
      stepClock();
      cycles++;
    end
    if (transmitData)
      reportTimeout("transmitData to fall");
    checkValue("clearDR", 32'(clearDR), 32'h0);              // drops together
    issuedCount++;
  endtask

  // one pulse per command, all of them finished
  task automatic waitIndicator();
    int cycles;
    if (runAborted)
      return;
    cycles = 0;
    while ((risingCount < issuedCount || rxIndicator) && cycles < PulseLimit)
    begin
      stepClock();
      cycles++;
    end
    if (risingCount < issuedCount || rxIndicator)
      reportTimeout("the rxIndicator pulse");
    else
      checkValue("rxIndicator pulses", 32'(risingCount), 32'(issuedCount));
  endtask

  // ------------------------------
  // stimulus from file
  // ------------------------------
  initial
  begin
    int          fileHandle;
    int          fieldCount;
    int          lineStatus;
    int          testNumber;
    int          errorsBefore;
    int          polls;
    logic        skipped;
    logic        isQuery;
    string       lineText;
    logic [7:0]  control;
    logic [31:0] data;
    logic [7:0]  expStatus;
    logic [31:0] expOutput;
    reset        = 1'b0;
    dataReceived = 1'b0;
    command      = '0;
    skipped      = 1'b0;
    testNumber   = 0;
    repeat (2) @(posedge masterClock);
    #1;
    reset = 1'b1;
    checkValue("reply.status", 32'(reply.status), 32'h0);
    checkValue("reply.outputWord", reply.outputWord, 32'h0);
    checkValue("transmitData", 32'(transmitData), 32'h0);
    checkValue("clearDR", 32'(clearDR), 32'h0);
    checkValue("rxIndicator", 32'(rxIndicator), 32'h0);
    $display("test 0 reset state: %s", (errorCount == 0) ? "ok" : "error");
    fileHandle = $fopen("testbench/sandbox_stimulus.txt", "r");
    if (fileHandle == 0)
    begin
      $display("could not open testbench/sandbox_stimulus.txt");
      runAborted = 1'b1;
    end
    while (!runAborted && !$feof(fileHandle))
    begin
      lineStatus = $fgets(lineText, fileHandle);
      fieldCount = $sscanf(lineText, "%h %h %h %h", control, data, expStatus, expOutput);
      if (lineStatus != 0 && fieldCount == 4)
      begin
        testNumber++;
        errorsBefore = errorCount;
        isQuery      = !control[`CMD_WRITE_BIT] && !control[`CMD_RUN_BIT];
        sendCommand(control, data);
        polls = 1;
        while (isQuery && !expStatus[0] && gotReply.status[0] && polls < PollLimit
               && !runAborted)
        begin
          waitIndicator();                    // poll again once drained
          sendCommand(control, data);
          polls++;
        end
        if (isQuery && !expStatus[0] && gotReply.status[0] && !runAborted)
        begin
          errorCount++;
          $display("engine still running after %0d queries", polls);
        end
        checkValue("reply.status", 32'(gotReply.status), 32'(expStatus));
        checkValue("reply.outputWord", gotReply.outputWord, expOutput);
        if (control[`CMD_RUN_BIT] && !control[`CMD_WRITE_BIT] && !skipped)
          skipped = 1'b1;                     // next command goes in while busy
        else
        begin
          waitIndicator();
          skipped = 1'b0;
        end
        $display("test %0d control %h data %h: %s", testNumber, control, data,
                 (errorCount == errorsBefore && !runAborted) ? "ok" : "error");
      end
    end
    if (fileHandle != 0)
      $fclose(fileHandle);
    $display("tests %0d, checks %0d, errors %0d", testNumber, checkCount, errorCount);
    if (errorCount == 0 && !runAborted && testNumber > 0)
      $display("Simulation passed");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

// File: testbench/sandbox_stimulus.txt
// control data expected_status expected_output, all hex
// control bit 1 writes at address bits 7..4, bit 0 runs, neither queries
00 00000000 00 00000000
02 a0000000 00 00000000
12 a1010101 00 00000000
22 a2020202 00 00000000
32 a3030303 00 00000000
42 a4040404 00 00000000
52 a5050505 00 00000000
62 a6060606 00 00000000
72 a7070707 00 00000000
82 a8080808 00 00000000
92 a9090909 00 00000000
a2 aa0a0a0a 00 00000000
b2 ab0b0b0b 00 00000000
c2 ac0c0c0c 00 00000000
d2 ad0d0d0d 00 00000000
e2 ae0e0e0e 00 00000000
f2 af0f0f0f 00 00000000
01 78787878 00 00000000
00 00000000 02 78787878
01 12345678 02 78787878
00 00000000 03 78787878
00 00000000 00 78787878
01 78787878 00 78787878
01 deadbeef 00 78787878
00 00000000 02 78787878
52 a5050605 02 78787878
01 78787978 02 78787878
00 00000000 02 78787978

// File: flist.f
+incdir+rtl
rtl/sandboxPkg.sv
rtl/workMemory.sv
rtl/memoryArbiter.sv
rtl/checksumEngine.sv
rtl/sandboxProcess.sv
rtl/sandboxTop.sv
testbench/sandbox_assertions.sv
testbench/sandboxTb.sv

// File: Makefile
TOP = sandboxTb

.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing --assert -f flist.f --top-module $(TOP) -o simv
	@out=$$(./obj_dir/simv); \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation passed"

lint:
	verilator --lint-only --timing --assert -Wall -f flist.f --top-module $(TOP)

clean:
	rm -rf obj_dir
